/* source/vc_macros.svh */
//--------------------
// Word width, FIFO depth and pointer width
// Occupancy thresholds for the flags
//--------------------

`ifndef VC_MACROS_SVH
`define VC_MACROS_SVH

// One word is a class bit on top of a 9-bit payload
`define VC_WORD_BITS 10

// Entries per class FIFO and the pointer width to address them
`define VC_DEPTH 8
`define VC_PTR_BITS 3

// almost_full and pause assert at or above this count
`define VC_ALMOST_FULL 6
// almost_empty asserts at or below this count, when not empty
`define VC_ALMOST_EMPTY 3

`endif

/* source/vc_pkg.sv */
//--------------------
// Shared types of the ingress buffer
// Class id, payload, word and occupancy count
//--------------------

`default_nettype none

`include "vc_macros.svh"

package vc_pkg;

    typedef enum logic {
        CLASS_0 = 1'b0,
        CLASS_1 = 1'b1
    } class_t;

    typedef logic [`VC_WORD_BITS-2:0] payload_t;

    // Class sits in the top bit of the word
    typedef struct packed {
        class_t   cls;
        payload_t payload;
    } word_t;

    // One bit wider than the pointers, so a full FIFO can be counted
    typedef logic [`VC_PTR_BITS:0] count_t;

endpackage

`default_nettype wire

/* source/vc_fifo_ram.sv */
//--------------------
// FIFO storage array
// Synchronous write, registered read
//--------------------

`default_nettype none

`include "vc_macros.svh"

module vc_fifo_ram (
    input  logic                    clk,
    input  logic                    write,
    input  logic                    read,
    input  logic [`VC_PTR_BITS-1:0] wr_ptr,
    input  logic [`VC_PTR_BITS-1:0] rd_ptr,
    input  vc_pkg::word_t           data_in,
    output vc_pkg::word_t           data_out
);

    vc_pkg::word_t mem [`VC_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Read port, the word stays on data_out until the next read
    always_ff @(posedge clk) begin
        if (read) begin
            data_out <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* source/vc_fifo.sv */
//--------------------
// Single class FIFO with pointers and occupancy count
// Status flags decoded from the count
//--------------------

`default_nettype none

`include "vc_macros.svh"

module vc_fifo (
    input  logic          clk,
    input  logic          reset,
    input  logic          push,
    input  logic          pop,
    input  vc_pkg::word_t push_word,
    output vc_pkg::word_t head_word,
    output logic          empty,
    output logic          almost_empty,
    output logic          almost_full,
    output logic          full,
    output logic          pause,
    output logic          overflow
);

    logic [`VC_PTR_BITS-1:0] wr_ptr;
    logic [`VC_PTR_BITS-1:0] rd_ptr;
    vc_pkg::count_t          count;
    logic                    push_ok;

    // A push to a full FIFO is dropped, even when a pop happens too
    assign push_ok = push && !full;

    vc_fifo_ram u_ram (
        .clk      (clk),
        .write    (push_ok),
        .read     (pop),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (push_word),
        .data_out (head_word)
    );

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on a simultaneous push and pop
    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
        end else begin
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Flags follow the count
    always_comb begin
        empty        = (count == '0);
        full         = (count == vc_pkg::count_t'(`VC_DEPTH));
        almost_full  = (count >= vc_pkg::count_t'(`VC_ALMOST_FULL));
        almost_empty = !empty && (count <= vc_pkg::count_t'(`VC_ALMOST_EMPTY));
    end

    // Same condition as almost_full; this one goes back to the sender
    assign pause = almost_full;

    // Dropped push, flagged in the same cycle
    assign overflow = push && full;

endmodule

`default_nettype wire

/* source/vc_arbiter.sv */
//--------------------
// Round-robin pop scheduler
// Merges both class FIFOs into one output stream
//--------------------

`default_nettype none

`include "vc_macros.svh"

module vc_arbiter (
    input  logic          clk,
    input  logic          reset,
    input  logic          hold,
    input  logic          empty_0,
    input  logic          empty_1,
    input  vc_pkg::word_t head_0,
    input  vc_pkg::word_t head_1,
    output logic          pop_0,
    output logic          pop_1,
    output logic          out_valid,
    output vc_pkg::word_t out_word
);

    vc_pkg::class_t last_served;
    vc_pkg::class_t popped_class;
    logic           popped;

    // Grant the other class when both have data, else whichever is ready
    always_comb begin
        pop_0 = !hold && !empty_0 && (empty_1 || last_served == vc_pkg::CLASS_1);
        pop_1 = !hold && !empty_1 && (empty_0 || last_served == vc_pkg::CLASS_0);
    end

    // Starts as if class 1 went last so class 0 wins first
    always_ff @(posedge clk) begin
        if (!reset) begin
            last_served <= vc_pkg::CLASS_1;
        end else if (pop_0) begin
            last_served <= vc_pkg::CLASS_0;
        end else if (pop_1) begin
            last_served <= vc_pkg::CLASS_1;
        end
    end

    // Remember the pop, the RAM read data shows up one cycle later
    always_ff @(posedge clk) begin
        if (!reset) begin
            popped       <= 1'b0;
            popped_class <= vc_pkg::CLASS_0;
        end else begin
            popped <= pop_0 || pop_1;
            if (pop_1) begin
                popped_class <= vc_pkg::CLASS_1;
            end else if (pop_0) begin
                popped_class <= vc_pkg::CLASS_0;
            end
        end
    end

    assign out_valid = popped;
    assign out_word  = (popped_class == vc_pkg::CLASS_1) ? head_1 : head_0;

endmodule

`default_nettype wire

/* source/vc_buffer_top.sv */
//--------------------
// Two-class ingress buffer top level
// Class steering, two FIFOs and the output arbiter
//--------------------

`default_nettype none

`include "vc_macros.svh"

module vc_buffer_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  vc_pkg::word_t in_word,
    input  logic          hold,
    output logic          out_valid,
    output vc_pkg::word_t out_word,
    output logic          full_0,
    output logic          almost_full_0,
    output logic          pause_0,
    output logic          empty_0,
    output logic          almost_empty_0,
    output logic          overflow_0,
    output logic          full_1,
    output logic          almost_full_1,
    output logic          pause_1,
    output logic          empty_1,
    output logic          almost_empty_1,
    output logic          overflow_1
);

    logic          push_0;
    logic          push_1;
    logic          pop_0;
    logic          pop_1;
    vc_pkg::word_t head_0;
    vc_pkg::word_t head_1;

    // Steer by the class bit of the incoming word
    assign push_0 = in_valid && (in_word.cls == vc_pkg::CLASS_0);
    assign push_1 = in_valid && (in_word.cls == vc_pkg::CLASS_1);

    vc_fifo u_fifo_0 (
        .clk          (clk),
        .reset        (reset),
        .push         (push_0),
        .pop          (pop_0),
        .push_word    (in_word),
        .head_word    (head_0),
        .empty        (empty_0),
        .almost_empty (almost_empty_0),
        .almost_full  (almost_full_0),
        .full         (full_0),
        .pause        (pause_0),
        .overflow     (overflow_0)
    );

    vc_fifo u_fifo_1 (
        .clk          (clk),
        .reset        (reset),
        .push         (push_1),
        .pop          (pop_1),
        .push_word    (in_word),
        .head_word    (head_1),
        .empty        (empty_1),
        .almost_empty (almost_empty_1),
        .almost_full  (almost_full_1),
        .full         (full_1),
        .pause        (pause_1),
        .overflow     (overflow_1)
    );

    vc_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .hold      (hold),
        .empty_0   (empty_0),
        .empty_1   (empty_1),
        .head_0    (head_0),
        .head_1    (head_1),
        .pop_0     (pop_0),
        .pop_1     (pop_1),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

endmodule

`default_nettype wire

/* tests/tb_vc_buffer.sv */
//--------------------
// Trace-driven testbench for the two-class ingress buffer
// Per-class scoreboards, flag and output checks, watchdog
//--------------------

`default_nettype none

`include "vc_macros.svh"

module tb_vc_buffer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_LINES  = 256;

    logic          clk;
    logic          reset;
    logic          in_valid;
    vc_pkg::word_t in_word;
    logic          hold;
    logic          out_valid;
    vc_pkg::word_t out_word;
    // Per class: full, almost_full, pause, empty, almost_empty, overflow
    logic [5:0]    flags_0;
    logic [5:0]    flags_1;

    // Trace contents, one entry per data line
    string                    t_name     [MAX_LINES];
    logic                     t_hold     [MAX_LINES];
    logic                     t_valid    [MAX_LINES];
    logic [`VC_WORD_BITS-1:0] t_word     [MAX_LINES];
    logic                     t_skip_0   [MAX_LINES];
    logic                     t_skip_1   [MAX_LINES];
    logic [5:0]               t_flags_0  [MAX_LINES];
    logic [5:0]               t_flags_1  [MAX_LINES];
    logic                     t_out_none [MAX_LINES];
    logic [`VC_WORD_BITS-1:0] t_out      [MAX_LINES];

    logic [`VC_WORD_BITS-1:0] sb_0 [$];
    logic [`VC_WORD_BITS-1:0] sb_1 [$];
    int                       n_lines;
    int                       errors;
    int                       checks;
    logic                     loaded;

    vc_buffer_top u_vc_buffer_top (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_word        (in_word),
        .hold           (hold),
        .out_valid      (out_valid),
        .out_word       (out_word),
        .full_0         (flags_0[5]),
        .almost_full_0  (flags_0[4]),
        .pause_0        (flags_0[3]),
        .empty_0        (flags_0[2]),
        .almost_empty_0 (flags_0[1]),
        .overflow_0     (flags_0[0]),
        .full_1         (flags_1[5]),
        .almost_full_1  (flags_1[4]),
        .pause_1        (flags_1[3]),
        .empty_1        (flags_1[2]),
        .almost_empty_1 (flags_1[1]),
        .overflow_1     (flags_1[0])
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          got;
        int          h;
        int          v;
        logic [15:0] w;
        logic [15:0] ow;
        logic [5:0]  b0;
        logic [5:0]  b1;
        string       text;
        string       name;
        string       f0;
        string       f1;
        string       outs;
        fd = $fopen("tests/vc_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("error: the trace file tests/vc_trace.txt could not be opened");
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            if ($fgets(text, fd) == 0) break;
            if (text.substr(0, 0) == "#") continue;
            got = $sscanf(text, "%s %d %d %h %s %s %s", name, h, v, w, f0, f1, outs);
            if (got <= 0) continue;
            if (got != 7) begin
                errors++;
                $display("error: a trace line could not be read: %s", text);
                continue;
            end
            b0 = '0;
            b1 = '0;
            ow = '0;
            got = $sscanf(f0, "%b", b0);
            got = $sscanf(f1, "%b", b1);
            if (outs != "-") got = $sscanf(outs, "%h", ow);
            t_name[n_lines]     = name;
            t_hold[n_lines]     = h[0];
            t_valid[n_lines]    = v[0];
            t_word[n_lines]     = w[`VC_WORD_BITS-1:0];
            t_skip_0[n_lines]   = (f0 == "skip");
            t_skip_1[n_lines]   = (f1 == "skip");
            t_flags_0[n_lines]  = b0;
            t_flags_1[n_lines]  = b1;
            t_out_none[n_lines] = (outs == "-");
            t_out[n_lines]      = ow[`VC_WORD_BITS-1:0];
            n_lines++;
        end
        $fclose(fd);
    endtask

    task automatic apply_line(input int i);
        hold     = t_hold[i];
        in_valid = t_valid[i];
        in_word  = t_word[i];
    endtask

    // Compare an output word with the oldest word waiting in its class
    task automatic score_output(input string test);
        logic [`VC_WORD_BITS-1:0] front;
        if (out_word.cls == vc_pkg::CLASS_0 && sb_0.size() > 0) begin
            front = sb_0.pop_front();
            check_value(test, "class 0 order", front, out_word);
        end else if (out_word.cls == vc_pkg::CLASS_1 && sb_1.size() > 0) begin
            front = sb_1.pop_front();
            check_value(test, "class 1 order", front, out_word);
        end else begin
            errors++;
            $display("error in %s: word %h came out but no word of its class was waiting",
                     test, out_word);
        end
    endtask

    // A push is dropped only where the trace expects overflow for its class
    task automatic record_push(input int i);
        logic dropped;
        if (t_word[i][`VC_WORD_BITS-1] == 1'b0) begin
            dropped = !t_skip_0[i] && t_flags_0[i][0];
            if (!dropped) sb_0.push_back(t_word[i]);
        end else begin
            dropped = !t_skip_1[i] && t_flags_1[i][0];
            if (!dropped) sb_1.push_back(t_word[i]);
        end
    endtask

    task automatic check_line(input int i);
        if (!t_skip_0[i]) check_value(t_name[i], "flags_0", t_flags_0[i], flags_0);
        if (!t_skip_1[i]) check_value(t_name[i], "flags_1", t_flags_1[i], flags_1);
        if (t_out_none[i]) begin
            check_value(t_name[i], "out_valid", 16'd0, out_valid);
        end else begin
            check_value(t_name[i], "out_valid", 16'd1, out_valid);
            check_value(t_name[i], "out_word", t_out[i], out_word);
        end
        if (out_valid) score_output(t_name[i]);
        if (t_valid[i]) record_push(i);
    endtask

    task automatic check_leftovers();
        while (sb_0.size() > 0) begin
            errors++;
            $display("error: class 0 word %h was accepted but never came out", sb_0.pop_front());
        end
        while (sb_1.size() > 0) begin
            errors++;
            $display("error: class 1 word %h was accepted but never came out", sb_1.pop_front());
        end
    endtask

    initial begin
        reset    = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        hold     = 1'b1;
        errors   = 0;
        checks   = 0;
        n_lines  = 0;
        loaded   = 1'b0;
        load_trace();
        if (n_lines == 0) begin
            errors++;
            $display("error: the trace holds no test lines");
        end
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b1;
        // Drive 1 ns after the edge, sample 1 ns before the next one
        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            #1;
            apply_line(i);
            #2;
            check_line(i);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        check_leftovers();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog, sized from the trace length
    initial begin
        wait (loaded === 1'b1);
        #((n_lines + 64) * CLK_PERIOD);
        $display("timeout: the run did not end within %0d clock cycles", n_lines + 64);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/vc_trace.txt */
# test hold in_valid in_word(hex) flags_0 flags_1 out_word(hex, - for none); flags may be skip
# flag bits, left to right: full almost_full pause empty almost_empty overflow
reset_state  1 0 000 000100 000100 -
round_robin  1 1 011 000100 000100 -
round_robin  1 1 211 000010 000100 -
round_robin  1 1 012 000010 000010 -
round_robin  1 1 212 000010 000010 -
round_robin  1 1 013 000010 000010 -
round_robin  1 1 213 000010 000010 -
round_robin  0 0 000 000010 000010 -
round_robin  0 0 000 000010 000010 011
round_robin  0 0 000 000010 000010 211
round_robin  0 0 000 000010 000010 012
round_robin  0 0 000 000010 000010 212
round_robin  0 0 000 000100 000010 013
round_robin  0 0 000 000100 000100 213
fill_hold    1 1 021 000100 000100 -
fill_hold    1 1 022 000010 000100 -
fill_hold    1 1 023 000010 000100 -
fill_hold    1 1 024 000010 000100 -
fill_hold    1 1 025 000000 000100 -
fill_hold    1 1 026 000000 000100 -
fill_hold    1 1 027 011000 000100 -
fill_hold    1 1 028 011000 000100 -
overflow     1 1 029 111001 000100 -
overflow     1 0 000 111000 000100 -
drain        0 0 000 111000 000100 -
drain        0 0 000 011000 000100 021
drain        0 0 000 011000 000100 022
drain        0 0 000 000000 000100 023
drain        0 0 000 000000 000100 024
drain        0 0 000 000010 000100 025
drain        0 0 000 000010 000100 026
drain        0 0 000 000010 000100 027
drain        0 0 000 000100 000100 028
streaming    0 1 031 000100 000100 -
streaming    0 1 231 000010 000100 -
streaming    0 1 032 000100 000010 031
streaming    0 1 232 000010 000100 231
streaming    0 1 033 000100 000010 032
streaming    0 0 000 000010 000100 232
streaming    0 1 233 000100 000100 033
streaming    0 1 234 000100 000010 -
streaming    0 1 034 000100 000010 233
streaming    0 0 000 000010 000100 234
streaming    0 0 000 000100 000100 034

/* filelist.f */
+incdir+source
source/vc_pkg.sv
source/vc_fifo_ram.sv
source/vc_fifo.sv
source/vc_arbiter.sv
source/vc_buffer_top.sv
tests/tb_vc_buffer.sv

/* Bender.yml */
package:
  name: vc_buffer

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/vc_pkg.sv
      - source/vc_fifo_ram.sv
      - source/vc_fifo.sv
      - source/vc_arbiter.sv
      - source/vc_buffer_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_vc_buffer.sv
